// File: list.f
+incdir+verification
verilog/regmap_pkg.sv
verilog/cipher_pkg.sv
verilog/xtea_core.sv
verilog/result_collect.sv
verilog/led_ctrl.sv
verilog/crypt_regs.sv
verilog/sonata_top.sv
verification/tb_sonata.sv

// File: run_sim.sh
#!/bin/sh
# builds tb_sonata with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_sonata -f list.f -o tb_sonata \
    && ./obj_dir/tb_sonata > sim.log 2>&1 \
    || { echo "simulation build or run did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference XTEA, v0 is the low half of the block, key word 0 the low 32 key bits
function automatic block_t xtea_encrypt(input key_t key, input block_t pt);
    half_t k [4];
    half_t y;
    half_t z;
    half_t s;
    for (int w = 0; w < 4; w++) begin
        k[w] = key[w*32 +: 32];
    end
    y = pt[31:0];
    z = pt[63:32];
    s = '0;
    for (int r = 0; r < XTEA_ROUNDS; r++) begin
        y = y + ((((z << 4) ^ (z >> 5)) + z) ^ (s + k[s[1:0]]));
        s = s + XTEA_DELTA;
        z = z + ((((y << 4) ^ (y >> 5)) + y) ^ (s + k[s[12:11]]));
    end
    return {z, y};
endfunction

// all bus tasks start and end DRIVE_DELAY after a rising edge
task automatic idle(input int n);
    repeat (n) @(posedge mainclk_buf);
    #DRIVE_DELAY;
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_write_i = 1'b1;
    idle(1);
    reg_write_i = 1'b0;
    case (addr) // shadow copy of the LED registers for the monitor
        REG_LED: begin
            test_q  = data[LED_TEST_BIT];
            flash_q = data[LED_FLASH_BIT];
        end
        REG_TEST_LEDS:         pattern_q[7:0]   = data;
        REG_TEST_LEDS + 8'd1:  pattern_q[15:8]  = data;
        REG_TEST_LEDS + 8'd2:  pattern_q[20:16] = data[4:0];
        default: ;
    endcase
endtask

task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    int waited;
    reg_addr_i = addr;
    reg_read_i = 1'b1;
    idle(1);
    reg_read_i = 1'b0;
    waited = 0;
    while (!reg_rvalid_o && waited < 4) begin
        idle(1);
        waited++;
    end
    if (!reg_rvalid_o) begin
        $display("no read response on the register bus for address %h", addr);
        err_other++;
    end
    data = reg_rdata_o;
endtask

// a done left over from the previous run is ignored until busy was seen
task automatic wait_for_done(input int max_polls);
    reg_data_t  st;
    logic [1:0] led_st;
    logic       seen_busy;
    int         polls;
    st        = '0;
    seen_busy = 1'b0;
    polls     = 0;
    while (polls < max_polls && !(seen_busy && st[STATUS_DONE_BIT])) begin
        led_st = usr_led_o[2:1]; // {done, busy} in normal mode
        read_reg(REG_STATUS, st);
        if (!test_q && !flash_q) begin
            assert (st[1:0] == led_st) else begin
                $display("ERR %0t: status %b but busy/done LEDs %b", $time, st[1:0], led_st);
                err_val++;
            end
        end
        if (st[STATUS_BUSY_BIT]) begin
            seen_busy = 1'b1;
        end
        polls++;
    end
    if (!(seen_busy && st[STATUS_DONE_BIT])) begin
        $display("status polling gave up after %0d reads without busy and then done", polls);
        err_other++;
    end else begin
        assert (st == 8'h02) else begin
            $display("ERR %0t: status at done is %h, expected 02", $time, st);
            err_val++;
        end
    end
endtask

`endif

// File: verification/tb_sonata.sv
`timescale 1ns/10ps

module tb_sonata import regmap_pkg::*, cipher_pkg::*;;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int NUM_CORES   = 4;
    localparam int HB_BIT      = 4;
    localparam int HB_HALF     = 1 << HB_BIT; // cycles between heartbeat toggles
    localparam int SEED        = 41782;
    localparam int CYCLE_LIMIT = 20000; // far longer than the full sequence

    logic         mainclk_buf;
    logic         rst_i;
    reg_addr_t    reg_addr_i;
    reg_data_t    reg_wdata_i;
    logic         reg_write_i;
    logic         reg_read_i;
    reg_data_t    reg_rdata_o;
    logic         reg_rvalid_o;
    switch_t      sw_i;
    logic [7:0]   usr_led_o;
    logic [8:0]   cheri_err_o;
    logic         led_legacy_o;
    logic         led_cheri_o;
    logic         led_halted_o;
    logic         led_bootok_o;

    int           err_val   = 0;
    int           err_other = 0;
    int           cycles    = 0;
    logic         test_q    = 1'b0;
    logic         flash_q   = 1'b0;
    led_pattern_t pattern_q = '0;
    int           hb_run    = 0;
    logic         hb_prev   = 1'b0;
    logic         hb_known  = 1'b0;

    `include "tb_model.svh"

    sonata_top #(
        .pNUM_CORES     (NUM_CORES),
        .pHEARTBEAT_BIT (HB_BIT)
    ) uut (
        .mainclk_buf  (mainclk_buf),
        .rst_i        (rst_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_write_i  (reg_write_i),
        .reg_read_i   (reg_read_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .sw_i         (sw_i),
        .usr_led_o    (usr_led_o),
        .cheri_err_o  (cheri_err_o),
        .led_legacy_o (led_legacy_o),
        .led_cheri_o  (led_cheri_o),
        .led_halted_o (led_halted_o),
        .led_bootok_o (led_bootok_o)
    );

    initial begin
        mainclk_buf = 1'b0;
        forever #(CLK_PERIOD/2) mainclk_buf = ~mainclk_buf;
    end

    always @(posedge mainclk_buf) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    rvalid_follows_read: assert property (@(posedge mainclk_buf) disable iff (rst_i)
        reg_rvalid_o == $past(reg_read_i))
        else begin
            $display("ERR %0t: reg_rvalid_o does not follow reg_read_i by one cycle", $time);
            err_val++;
        end

    // LEDs are stable at the falling edge
    always @(negedge mainclk_buf) begin
        if (rst_i || (test_q && !flash_q)) begin
            hb_known = 1'b0;
            hb_run   = 0;
        end else if (hb_run == 0) begin
            hb_run = 1; // first heartbeat sample after reset or test mode
        end else if (usr_led_o[0] != hb_prev) begin
            if (hb_known) begin
                assert (hb_run == HB_HALF) else begin
                    $display("ERR %0t: heartbeat held %0d cycles, expected %0d",
                             $time, hb_run, HB_HALF);
                    err_val++;
                end
            end
            hb_known = 1'b1;
            hb_run   = 1;
        end else begin
            hb_run++;
            assert (hb_run != HB_HALF + 1) else begin
                $display("ERR %0t: heartbeat stuck for more than %0d cycles", $time, HB_HALF);
                err_val++;
            end
        end
        hb_prev = usr_led_o[0];
        if (!rst_i && flash_q) begin
            assert ({usr_led_o, cheri_err_o, led_legacy_o, led_cheri_o, led_halted_o,
                     led_bootok_o} == {21{usr_led_o[0]}}) else begin
                $display("ERR %0t: flash all, LEDs differ from the heartbeat", $time);
                err_val++;
            end
        end else if (!rst_i && test_q) begin
            assert ({led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o, cheri_err_o,
                     usr_led_o} == pattern_q) else begin
                $display("ERR %0t: test mode LEDs differ from pattern %h", $time, pattern_q);
                err_val++;
            end
        end else if (!rst_i) begin
            assert ({led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o, cheri_err_o,
                     usr_led_o[7:3]} == '0) else begin
                $display("ERR %0t: normal mode, unused LEDs are lit", $time);
                err_val++;
            end
        end
    end

    task automatic apply_reset();
        rst_i   = 1'b1;
        test_q  = 1'b0;
        flash_q = 1'b0;
        pattern_q = '0;
        idle(10);
        rst_i = 1'b0;
    endtask

    task automatic check_read(input reg_addr_t addr, input reg_data_t exp, input string what);
        reg_data_t got;
        read_reg(addr, got);
        assert (got === exp) else begin
            $display("ERR %0t: %s at %h read %h, expected %h", $time, what, addr, got, exp);
            err_val++;
        end
    endtask

    function automatic void check_block(input block_t got, input block_t exp, input string what);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_val++;
        end
    endfunction

    task automatic write_key_text(input key_t key, input block_t text);
        for (int n = 0; n < 16; n++) begin
            write_reg(REG_KEY + reg_addr_t'(n), key[n*8 +: 8]);
        end
        for (int n = 0; n < 8; n++) begin
            write_reg(REG_TEXT + reg_addr_t'(n), text[n*8 +: 8]);
        end
    endtask

    task automatic read_ct(input core_idx_t sel, output block_t ct);
        reg_data_t b;
        write_reg(REG_CORE_SEL, sel);
        idle(1); // ciphertext register lags the select
        for (int n = 0; n < 8; n++) begin
            read_reg(REG_CT + reg_addr_t'(n), b);
            ct[n*8 +: 8] = b;
        end
    endtask

    initial begin
        key_t         key;
        block_t       text_a;
        block_t       text_b;
        block_t       ct;
        core_mask_t   en;
        switch_t      sw;
        led_pattern_t pat;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        reg_write_i = 1'b0;
        reg_read_i  = 1'b0;
        sw_i        = '0;
        rst_i       = 1'b1;
        void'($urandom(SEED));
        apply_reset();

        assert (reg_rvalid_o == 1'b0) else begin
            $display("ERR %0t: reg_rvalid_o high after reset", $time);
            err_val++;
        end
        check_read(REG_STATUS, 8'h00, "status after reset");
        idle(4 * HB_HALF);

        // register read back
        key    = {$urandom, $urandom, $urandom, $urandom};
        text_a = {$urandom, $urandom};
        write_key_text(key, text_a);
        for (int n = 0; n < 16; n++) begin
            check_read(REG_KEY + reg_addr_t'(n), key[n*8 +: 8], "key byte");
        end
        for (int n = 0; n < 8; n++) begin
            check_read(REG_TEXT + reg_addr_t'(n), text_a[n*8 +: 8], "text byte");
        end
        en = core_mask_t'($urandom);
        write_reg(REG_CORES_EN, en);
        check_read(REG_CORES_EN, en, "core enable");
        sw   = switch_t'($urandom);
        sw_i = sw;
        check_read(REG_SWITCHES, sw[7:0], "switches low");
        check_read(REG_SWITCHES + 8'd1, sw[15:8], "switches high");

        // one ciphertext per core index with all cores on
        key    = {$urandom, $urandom, $urandom, $urandom};
        text_a = {$urandom, $urandom};
        write_key_text(key, text_a);
        write_reg(REG_CORES_EN, 8'h0F);
        write_reg(REG_CTRL, 8'h01);
        wait_for_done(100);
        for (int i = 0; i < NUM_CORES; i++) begin
            read_ct(core_idx_t'(i), ct);
            check_block(ct, xtea_encrypt(key, text_a ^ block_t'(i)),
                        $sformatf("core %0d ciphertext", i));
        end

        // core 2 disabled after a fresh reset
        apply_reset();
        text_a = {$urandom, $urandom};
        write_key_text(key, text_a);
        write_reg(REG_CORES_EN, 8'h0B);
        write_reg(REG_CTRL, 8'h01);
        wait_for_done(100);
        read_ct(8'd2, ct);
        check_block(ct, '0, "disabled core 2 ciphertext");
        read_ct(8'd5, ct);
        check_block(ct, '0, "ciphertext for select 5");
        read_ct(8'd0, ct);
        check_block(ct, xtea_encrypt(key, text_a), "core 0 ciphertext");

        // starts while running are ignored
        text_a = {$urandom, $urandom};
        text_b = {$urandom, $urandom};
        write_key_text(key, text_a);
        write_reg(REG_CORES_EN, 8'h0F);
        write_reg(REG_CTRL, 8'h01);
        write_reg(REG_TEXT, ~text_a[7:0]); // a restart would pick this byte up
        write_reg(REG_CTRL, 8'h01); // before busy is visible
        idle(5);
        for (int n = 0; n < 8; n++) begin
            write_reg(REG_TEXT + reg_addr_t'(n), text_b[n*8 +: 8]);
        end
        write_reg(REG_CTRL, 8'h01);
        wait_for_done(100);
        read_ct(8'd0, ct);
        check_block(ct, xtea_encrypt(key, text_a), "core 0 after ignored start");
        read_ct(8'd3, ct);
        check_block(ct, xtea_encrypt(key, text_a ^ 64'd3), "core 3 after ignored start");

        // LED modes checked by the negedge monitor
        pat = led_pattern_t'($urandom);
        write_reg(REG_TEST_LEDS, pat[7:0]);
        write_reg(REG_TEST_LEDS + 8'd1, pat[15:8]);
        write_reg(REG_TEST_LEDS + 8'd2, {3'b000, pat[20:16]});
        write_reg(REG_LED, 8'h01);
        idle(20);
        write_reg(REG_LED, 8'h03);
        idle(4 * HB_HALF);
        write_reg(REG_LED, 8'h00);
        idle(4 * HB_HALF);
        assert (usr_led_o[2] == 1'b1) else begin
            $display("ERR %0t: done LED low while done is set", $time);
            err_val++;
        end

        $display("errors: %0d wrong values, %0d other", err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/sonata_top.sv
`timescale 1ns/10ps

module sonata_top import regmap_pkg::*, cipher_pkg::*; #(
    parameter int pNUM_CORES     = 4,
    parameter int pHEARTBEAT_BIT = 23
) (
    input  logic        mainclk_buf,
    input  logic        rst_i,

    input  reg_addr_t   reg_addr_i,
    input  reg_data_t   reg_wdata_i,
    input  logic        reg_write_i,
    input  logic        reg_read_i,
    output reg_data_t   reg_rdata_o,
    output logic        reg_rvalid_o,

    input  switch_t     sw_i,

    output logic [7:0]  usr_led_o,
    output logic [8:0]  cheri_err_o,
    output logic        led_legacy_o,
    output logic        led_cheri_o,
    output logic        led_halted_o,
    output logic        led_bootok_o
);

    key_t         crypt_key;
    block_t       crypt_text;
    core_mask_t   crypt_load;
    core_idx_t    core_sel;
    logic         crypt_busy;
    logic         crypt_done;
    block_t       crypt_ct;

    logic [pNUM_CORES-1:0] core_busy;
    block_t                core_ct [pNUM_CORES];

    logic         led_test_mode;
    logic         led_flash_all;
    led_pattern_t test_leds;

    crypt_regs #(
        .pNUM_CORES      (pNUM_CORES)
    ) u_crypt_regs (
        .mainclk_buf     (mainclk_buf),
        .rst_i           (rst_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_write_i     (reg_write_i),
        .reg_read_i      (reg_read_i),
        .reg_rdata_o     (reg_rdata_o),
        .reg_rvalid_o    (reg_rvalid_o),
        .sw_i            (sw_i),
        .busy_i          (crypt_busy),
        .done_i          (crypt_done),
        .ct_i            (crypt_ct),
        .key_o           (crypt_key),
        .text_o          (crypt_text),
        .load_o          (crypt_load),
        .core_sel_o      (core_sel),
        .led_test_mode_o (led_test_mode),
        .led_flash_all_o (led_flash_all),
        .test_leds_o     (test_leds)
    );

    // each core works on the text xored with its own index
    for (genvar i = 0; i < pNUM_CORES; i++) begin : g_core
        xtea_core u_xtea_core (
            .mainclk_buf (mainclk_buf),
            .rst_i       (rst_i),
            .load_i      (crypt_load[i]),
            .key_i       (crypt_key),
            .data_i      (crypt_text ^ block_t'(i)),
            .data_o      (core_ct[i]),
            .busy_o      (core_busy[i])
        );
    end

    result_collect #(
        .pNUM_CORES  (pNUM_CORES)
    ) u_result_collect (
        .mainclk_buf (mainclk_buf),
        .rst_i       (rst_i),
        .load_i      (crypt_load),
        .core_busy_i (core_mask_t'(core_busy)),
        .core_data_i (core_ct),
        .core_sel_i  (core_sel),
        .busy_o      (crypt_busy),
        .done_o      (crypt_done),
        .ct_o        (crypt_ct)
    );

    led_ctrl #(
        .pHEARTBEAT_BIT (pHEARTBEAT_BIT)
    ) u_led_ctrl (
        .mainclk_buf    (mainclk_buf),
        .rst_i          (rst_i),
        .test_mode_i    (led_test_mode),
        .flash_all_i    (led_flash_all),
        .test_leds_i    (test_leds),
        .busy_i         (crypt_busy),
        .done_i         (crypt_done),
        .usr_led_o      (usr_led_o),
        .cheri_err_o    (cheri_err_o),
        .led_legacy_o   (led_legacy_o),
        .led_cheri_o    (led_cheri_o),
        .led_halted_o   (led_halted_o),
        .led_bootok_o   (led_bootok_o)
    );

endmodule

// File: verilog/crypt_regs.sv
`timescale 1ns/10ps

module crypt_regs import regmap_pkg::*, cipher_pkg::*; #(
    parameter int pNUM_CORES = 4
) (
    input  logic         mainclk_buf,
    input  logic         rst_i,

    input  reg_addr_t    reg_addr_i,
    input  reg_data_t    reg_wdata_i,
    input  logic         reg_write_i,
    input  logic         reg_read_i,
    output reg_data_t    reg_rdata_o,
    output logic         reg_rvalid_o,

    input  switch_t      sw_i,
    input  logic         busy_i,
    input  logic         done_i,
    input  block_t       ct_i,

    output key_t         key_o,
    output block_t       text_o,
    output core_mask_t   load_o,
    output core_idx_t    core_sel_o,
    output logic         led_test_mode_o,
    output logic         led_flash_all_o,
    output led_pattern_t test_leds_o
);

    localparam core_mask_t CORE_MASK = core_mask_t'((1 << pNUM_CORES) - 1);

    key_t         key_r;
    block_t       text_r;
    core_mask_t   cores_en_r;
    core_idx_t    core_sel_r;
    logic         led_test_r;
    logic         led_flash_r;
    led_pattern_t test_leds_r;
    core_mask_t   load_r;
    logic         load_d;
    reg_data_t    rd_mux;
    reg_data_t    rdata_r;
    logic         rvalid_r;
    logic         start_wr;
    logic         start_block;

    assign start_wr = reg_write_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[CTRL_START_BIT];
    // busy from result_collect lags the load by two cycles, cover that gap
    assign start_block = busy_i || (|load_r) || load_d;

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            key_r       <= '0;
            text_r      <= '0;
            cores_en_r  <= '0;
            core_sel_r  <= '0;
            led_test_r  <= 1'b0;
            led_flash_r <= 1'b0;
            test_leds_r <= '0;
        end else if (reg_write_i) begin
            if (reg_addr_i[7:4] == REG_KEY[7:4]) begin
                key_r[reg_addr_i[3:0]*8 +: 8] <= reg_wdata_i;
            end else if (reg_addr_i[7:3] == REG_TEXT[7:3]) begin
                text_r[reg_addr_i[2:0]*8 +: 8] <= reg_wdata_i;
            end else begin
                case (reg_addr_i)
                    REG_CORES_EN:          cores_en_r <= reg_wdata_i;
                    REG_CORE_SEL:          core_sel_r <= reg_wdata_i;
                    REG_LED: begin
                        led_test_r  <= reg_wdata_i[LED_TEST_BIT];
                        led_flash_r <= reg_wdata_i[LED_FLASH_BIT];
                    end
                    REG_TEST_LEDS:         test_leds_r[7:0]   <= reg_wdata_i;
                    REG_TEST_LEDS + 8'd1:  test_leds_r[15:8]  <= reg_wdata_i;
                    REG_TEST_LEDS + 8'd2:  test_leds_r[20:16] <= reg_wdata_i[4:0];
                    default: ;
                endcase
            end
        end
    end

    // one-cycle load, masked by enables and core count
    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            load_r <= '0;
            load_d <= 1'b0;
        end else begin
            load_r <= (start_wr && !start_block) ? (cores_en_r & CORE_MASK) : '0;
            load_d <= |load_r;
        end
    end

    always_comb begin
        rd_mux = '0;
        if (reg_addr_i[7:4] == REG_KEY[7:4]) begin
            rd_mux = key_r[reg_addr_i[3:0]*8 +: 8];
        end else if (reg_addr_i[7:3] == REG_TEXT[7:3]) begin
            rd_mux = text_r[reg_addr_i[2:0]*8 +: 8];
        end else if (reg_addr_i[7:3] == REG_CT[7:3]) begin
            rd_mux = ct_i[reg_addr_i[2:0]*8 +: 8];
        end else begin
            case (reg_addr_i)
                REG_CORES_EN: rd_mux = cores_en_r;
                REG_CORE_SEL: rd_mux = core_sel_r;
                REG_STATUS: begin
                    rd_mux[STATUS_BUSY_BIT] = busy_i;
                    rd_mux[STATUS_DONE_BIT] = done_i;
                end
                REG_LED: begin
                    rd_mux[LED_TEST_BIT]  = led_test_r;
                    rd_mux[LED_FLASH_BIT] = led_flash_r;
                end
                REG_TEST_LEDS:         rd_mux = test_leds_r[7:0];
                REG_TEST_LEDS + 8'd1:  rd_mux = test_leds_r[15:8];
                REG_TEST_LEDS + 8'd2:  rd_mux = {3'b000, test_leds_r[20:16]};
                REG_SWITCHES:          rd_mux = sw_i[7:0];
                REG_SWITCHES + 8'd1:   rd_mux = sw_i[15:8];
                default:               rd_mux = '0; // ctrl and unknown addresses
            endcase
        end
    end

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            rdata_r  <= '0;
            rvalid_r <= 1'b0;
        end else begin
            rvalid_r <= reg_read_i;
            if (reg_read_i) begin
                rdata_r <= rd_mux;
            end
        end
    end

    assign reg_rdata_o     = rdata_r;
    assign reg_rvalid_o    = rvalid_r;
    assign key_o           = key_r;
    assign text_o          = text_r;
    assign load_o          = load_r;
    assign core_sel_o      = core_sel_r;
    assign led_test_mode_o = led_test_r;
    assign led_flash_all_o = led_flash_r;
    assign test_leds_o     = test_leds_r;

endmodule

// File: verilog/led_ctrl.sv
`timescale 1ns/10ps

module led_ctrl import regmap_pkg::*; #(
    parameter int pHEARTBEAT_BIT = 23
) (
    input  logic         mainclk_buf,
    input  logic         rst_i,
    input  logic         test_mode_i,
    input  logic         flash_all_i,
    input  led_pattern_t test_leds_i,
    input  logic         busy_i,
    input  logic         done_i,
    output logic [7:0]   usr_led_o,
    output logic [8:0]   cheri_err_o,
    output logic         led_legacy_o,
    output logic         led_cheri_o,
    output logic         led_halted_o,
    output logic         led_bootok_o
);

    logic [pHEARTBEAT_BIT:0] hb_cnt;
    logic                    heartbeat;

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign heartbeat = hb_cnt[pHEARTBEAT_BIT];

    always_comb begin
        if (flash_all_i) begin // overrides test mode
            usr_led_o    = {8{heartbeat}};
            cheri_err_o  = {9{heartbeat}};
            led_legacy_o = heartbeat;
            led_cheri_o  = heartbeat;
            led_halted_o = heartbeat;
            led_bootok_o = heartbeat;
        end else if (test_mode_i) begin
            usr_led_o    = test_leds_i[7:0];
            cheri_err_o  = test_leds_i[16:8];
            led_legacy_o = test_leds_i[17];
            led_cheri_o  = test_leds_i[18];
            led_halted_o = test_leds_i[19];
            led_bootok_o = test_leds_i[20];
        end else begin
            usr_led_o    = {5'b00000, done_i, busy_i, heartbeat};
            cheri_err_o  = '0;
            led_legacy_o = 1'b0;
            led_cheri_o  = 1'b0;
            led_halted_o = 1'b0;
            led_bootok_o = 1'b0;
        end
    end

endmodule

// File: verilog/result_collect.sv
`timescale 1ns/10ps

module result_collect import cipher_pkg::*; #(
    parameter int pNUM_CORES = 4
) (
    input  logic       mainclk_buf,
    input  logic       rst_i,
    input  core_mask_t load_i,
    input  core_mask_t core_busy_i,
    input  block_t     core_data_i [pNUM_CORES],
    input  core_idx_t  core_sel_i,
    output logic       busy_o,
    output logic       done_o,
    output block_t     ct_o
);

    logic   busy_r;
    logic   busy_d;
    logic   done_r;
    block_t ct_r;
    block_t ct_sel;

    // selects past the last core fall through to zero
    always_comb begin
        ct_sel = '0;
        for (int j = 0; j < pNUM_CORES; j++) begin
            if (core_sel_i == core_idx_t'(j)) begin
                ct_sel = core_data_i[j];
            end
        end
    end

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            busy_r <= 1'b0;
            busy_d <= 1'b0;
            done_r <= 1'b0;
            ct_r   <= '0;
        end else begin
            busy_r <= |core_busy_i;
            busy_d <= busy_r;
            ct_r   <= ct_sel;
            if (|load_i) begin
                done_r <= 1'b0; // new run wins over a late done
            end else if (busy_d && !busy_r) begin
                done_r <= 1'b1;
            end
        end
    end

    assign busy_o = busy_r;
    assign done_o = done_r;
    assign ct_o   = ct_r;

endmodule

// File: verilog/xtea_core.sv
`timescale 1ns/10ps

module xtea_core import cipher_pkg::*; (
    input  logic   mainclk_buf,
    input  logic   rst_i,
    input  logic   load_i,
    input  key_t   key_i,
    input  block_t data_i,
    output block_t data_o,
    output logic   busy_o
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t     state;
    round_cnt_t round_cnt;
    half_t      v0;
    half_t      v1;
    half_t      sum;
    half_t      v0_next;
    half_t      v1_next;
    half_t      sum_next;

    // key word 0 sits in key bits 31:0
    function automatic half_t key_word(input key_t key, input logic [1:0] idx);
        return key[idx*32 +: 32];
    endfunction

    function automatic half_t mix(input half_t v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    // one full cycle, both halves
    always_comb begin
        v0_next  = v0 + (mix(v1) ^ (sum + key_word(key_i, sum[1:0])));
        sum_next = sum + XTEA_DELTA;
        v1_next  = v1 + (mix(v0_next) ^ (sum_next + key_word(key_i, sum_next[12:11])));
    end

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            state     <= ST_IDLE;
            round_cnt <= '0;
            sum       <= '0;
            v0        <= '0;
            v1        <= '0;
        end else if (load_i) begin // restarts a running core too
            state     <= ST_RUN;
            round_cnt <= '0;
            sum       <= '0;
            v0        <= data_i[31:0];  // v0 is the low half
            v1        <= data_i[63:32];
        end else if (state == ST_RUN) begin
            v0        <= v0_next;
            v1        <= v1_next;
            sum       <= sum_next;
            round_cnt <= round_cnt + 1'b1;
            if (round_cnt == round_cnt_t'(XTEA_ROUNDS - 1)) begin
                state <= ST_IDLE;
            end
        end
    end

    assign data_o = {v1, v0};
    assign busy_o = (state == ST_RUN);

endmodule

// File: verilog/cipher_pkg.sv
package cipher_pkg;

    typedef logic [63:0]  block_t;
    typedef logic [127:0] key_t;
    typedef logic [31:0]  half_t;

    // one count per full XTEA cycle (two Feistel rounds)
    typedef logic [5:0] round_cnt_t;

    localparam int    XTEA_ROUNDS = 32;
    localparam half_t XTEA_DELTA  = 32'h9E37_79B9;

    // sized for the largest build of 8 cores
    typedef logic [7:0] core_mask_t;
    typedef logic [7:0] core_idx_t;

endpackage

// File: verilog/regmap_pkg.sv
package regmap_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [20:0] led_pattern_t;
    typedef logic [15:0] switch_t;

    // first byte of each register, multi-byte registers are lsb first
    localparam reg_addr_t REG_KEY       = 8'h00; // 16 bytes
    localparam reg_addr_t REG_TEXT      = 8'h10; // 8 bytes
    localparam reg_addr_t REG_CORES_EN  = 8'h18;
    localparam reg_addr_t REG_CORE_SEL  = 8'h19;
    localparam reg_addr_t REG_CTRL      = 8'h1A;
    localparam reg_addr_t REG_STATUS    = 8'h1B;
    localparam reg_addr_t REG_CT        = 8'h20; // 8 bytes, read only
    localparam reg_addr_t REG_LED       = 8'h28;
    localparam reg_addr_t REG_TEST_LEDS = 8'h29; // 0x29..0x2B
    localparam reg_addr_t REG_SWITCHES  = 8'h2C; // 0x2C..0x2D, read only

    // bit positions inside the control and status bytes
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;
    localparam int LED_TEST_BIT    = 0;
    localparam int LED_FLASH_BIT   = 1;

endpackage
